/* bench/fe_top_tb.sv */
//==========================================================================
// testbench for the fetch front end: seeded random commands and queue
// back-pressure, every cycle compared with a cycle model of the rules
//==========================================================================
`default_nettype none

module fe_top_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import fe_pkg::*;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 5;
   localparam int TEST_CYCLES   = 3000;
   localparam int MARGIN_CYCLES = 100;
   localparam int POOL_SIZE     = 12;

   logic               clk_i;
   logic               reset_i;
   logic               fe_cmd_v_i;
   fe_opcode_e         fe_cmd_opcode_i;
   fe_cmd_operand_u    fe_cmd_operand_i;
   logic               fe_queue_v_o;
   logic               fe_queue_ready_i;
   fe_msg_type_e       fe_queue_type_o;
   logic [VADDR_W-1:0] fe_queue_vaddr_o;
   logic [PADDR_W-1:0] fe_queue_paddr_o;

   integer             seed;

   // model state, holds the values expected after the last edge
   logic               m_wait;
   logic [VADDR_W-1:0] m_pc;
   logic               m_tlb_v [ITLB_ENTRIES];
   logic [VTAG_W-1:0]  m_tlb_vtag [ITLB_ENTRIES];
   logic [PTAG_W-1:0]  m_tlb_ptag [ITLB_ENTRIES];
   int                 m_rr;
   logic               m_q_v;
   fe_msg_type_e       m_q_type;
   logic [VADDR_W-1:0] m_q_vaddr;
   logic [PADDR_W-1:0] m_q_paddr;
   int                 low_left;
   int                 fetch_count;
   int                 evict_count;

   fe_top u_fe_top
   (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_opcode_i  (fe_cmd_opcode_i),
      .fe_cmd_operand_i (fe_cmd_operand_i),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i),
      .fe_queue_type_o  (fe_queue_type_o),
      .fe_queue_vaddr_o (fe_queue_vaddr_o),
      .fe_queue_paddr_o (fe_queue_paddr_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic stop_with_failure();
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic model_fill(input logic [VTAG_W-1:0] vtag, input logic [PTAG_W-1:0] ptag);
      int idx;
      idx = -1;
      for (int i = 0; i < ITLB_ENTRIES; i++)
         if (m_tlb_v[i] && m_tlb_vtag[i] == vtag)
            idx = i;
      // a page already present keeps its slot
      if (idx < 0)
      begin
         idx = m_rr;
         if (m_tlb_v[idx])
            evict_count++;
         m_rr = (m_rr + 1) % ITLB_ENTRIES;
      end
      m_tlb_v[idx]    = 1'b1;
      m_tlb_vtag[idx] = vtag;
      m_tlb_ptag[idx] = ptag;
   endtask

   task automatic model_step();
      logic              do_redirect;
      logic              do_fill;
      logic              hit;
      logic              issue;
      logic [PTAG_W-1:0] ptag;
      do_redirect = fe_cmd_v_i && (fe_cmd_opcode_i == e_op_pc_redirect);
      do_fill     = fe_cmd_v_i && (fe_cmd_opcode_i == e_op_itlb_fill);
      hit  = 1'b0;
      ptag = '0;
      for (int i = 0; i < ITLB_ENTRIES; i++)
         if (m_tlb_v[i] && m_tlb_vtag[i] == m_pc[VADDR_W-1:PAGE_OFFSET_W])
         begin
            hit  = 1'b1;
            ptag = m_tlb_ptag[i];
         end
      issue = !m_wait && !do_redirect && !do_fill && (!m_q_v || fe_queue_ready_i);
      if (issue)
      begin
         m_q_v     = 1'b1;
         m_q_type  = hit ? e_msg_fetch : e_msg_itlb_miss;
         m_q_vaddr = m_pc;
         m_q_paddr = hit ? {ptag, m_pc[PAGE_OFFSET_W-1:0]} : '0;
         if (hit)
            fetch_count++;
      end
      else if (fe_queue_ready_i)
         m_q_v = 1'b0;
      if (m_wait)
         m_wait = !(do_redirect || do_fill);
      else if (issue && !hit)
         m_wait = 1'b1;
      if (do_redirect)
         m_pc = fe_cmd_operand_i.redirect.target;
      else if (issue && hit)
         m_pc = m_pc + INSTR_BYTES;
      if (do_fill)
         model_fill(fe_cmd_operand_i.fill.vtag, fe_cmd_operand_i.fill.ptag);
   endtask

   task automatic drive_inputs();
      logic [31:0]       r;
      logic [31:0]       pick;
      logic [63:0]       noise;
      logic [VTAG_W-1:0] vtag;
      logic [11:0]       offset;
      fe_cmd_operand_u   op;
      r     = $random(seed);
      pick  = $random(seed);
      pick  = pick % 100;
      noise = {$random(seed), $random(seed)};
      vtag  = m_wait ? m_pc[VADDR_W-1:PAGE_OFFSET_W] : VTAG_W'(32'd1 + r % POOL_SIZE);
      offset = {r[15:6], 2'b00};
      // targets near the page end make the stream cross pages
      if (r[16])
         offset[11:6] = 6'h3f;
      op = '0;
      fe_cmd_v_i = 1'b1;
      if (m_wait ? pick < 45 : (pick >= 3 && pick < 6))
      begin
         op.fill.vtag    = vtag;
         op.fill.ptag    = noise[15:0];
         fe_cmd_opcode_i = e_op_itlb_fill;
      end
      else if (m_wait ? pick < 55 : pick < 3)
      begin
         op.redirect.target = {VTAG_W'(32'd1 + r % POOL_SIZE), offset};
         fe_cmd_opcode_i    = e_op_pc_redirect;
      end
      else if (m_wait ? pick < 60 : pick < 8)
      begin
         op              = noise[OPERAND_W-1:0];
         fe_cmd_opcode_i = r[0] ? e_op_nop : e_op_reserved;
      end
      else
      begin
         // idle, opcode and operand are garbage
         fe_cmd_v_i      = 1'b0;
         op              = noise[OPERAND_W-1:0];
         fe_cmd_opcode_i = fe_opcode_e'(noise[37:36]);
      end
      fe_cmd_operand_i = op;
      if (low_left > 0)
      begin
         fe_queue_ready_i = 1'b0;
         low_left--;
      end
      else if (noise[63:61] == 3'd0)
      begin
         fe_queue_ready_i = 1'b0;
         low_left         = int'(noise[59:57]);
      end
      else
         fe_queue_ready_i = 1'b1;
   endtask

   initial
   begin
      #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("watchdog expired, the test did not finish in time");
      stop_with_failure();
   end

   initial
   begin
      seed             = 32'h5381_964e;
      reset_i          = 1'b1;
      fe_cmd_v_i       = 1'b0;
      fe_cmd_opcode_i  = e_op_nop;
      fe_cmd_operand_i = '0;
      fe_queue_ready_i = 1'b0;
      m_wait      = 1'b0;
      m_pc        = FIRST_PC;
      m_rr        = 0;
      m_q_v       = 1'b0;
      low_left    = 0;
      fetch_count = 0;
      evict_count = 0;
      for (int i = 0; i < ITLB_ENTRIES; i++)
         m_tlb_v[i] = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      for (int cycle = 0; cycle < TEST_CYCLES; cycle++)
      begin
         check_value("fe_queue_v_o", 64'(fe_queue_v_o), 64'(m_q_v));
         if (m_q_v)
         begin
            check_value("fe_queue_type_o", 64'(fe_queue_type_o), 64'(m_q_type));
            check_value("fe_queue_vaddr_o", 64'(fe_queue_vaddr_o), 64'(m_q_vaddr));
            check_value("fe_queue_paddr_o", 64'(fe_queue_paddr_o), 64'(m_q_paddr));
         end
         drive_inputs();
         model_step();
         @(negedge clk_i);
      end
      if (fetch_count == 0 || evict_count == 0)
      begin
         $display("stimulus too weak: %0d fetches and %0d evictions seen",
                  fetch_count, evict_count);
         stop_with_failure();
      end
      else
      begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* hw/fe_fetch_ctrl.sv */
//==========================================================================
// fetch control: decodes back-end commands and, in RUN, issues a fetch or
// itlb-miss entry for the current pc; a miss parks the FSM in WAIT
//==========================================================================
`default_nettype none

module fe_fetch_ctrl
(
   input  logic                        clk_i,
   input  logic                        reset_i,

   input  logic                        cmd_v_i,
   input  fe_pkg::fe_opcode_e          cmd_opcode_i,
   input  fe_pkg::fe_cmd_operand_u     cmd_operand_i,

   input  logic [fe_pkg::VADDR_W-1:0]  pc_i,
   input  logic                        tlb_hit_i,
   input  logic [fe_pkg::PTAG_W-1:0]   tlb_ptag_i,
   input  logic                        can_load_i,

   output logic                        pc_advance_o,
   output logic                        pc_load_o,
   output logic [fe_pkg::VADDR_W-1:0]  pc_target_o,

   output logic                        tlb_w_v_o,
   output logic [fe_pkg::VTAG_W-1:0]   tlb_w_vtag_o,
   output logic [fe_pkg::PTAG_W-1:0]   tlb_w_ptag_o,

   output logic                        entry_load_o,
   output fe_pkg::fe_msg_type_e        entry_type_o,
   output logic [fe_pkg::VADDR_W-1:0]  entry_vaddr_o,
   output logic [fe_pkg::PADDR_W-1:0]  entry_paddr_o
);

   import fe_pkg::*;

   // high while waiting on the back end after an itlb miss
   logic wait_r;

   logic do_redirect;
   logic do_fill;
   logic issue;

   always_comb
   begin
      do_redirect = 1'b0;
      do_fill     = 1'b0;
      case (cmd_opcode_i)
         e_op_pc_redirect:
         begin
            do_redirect = cmd_v_i;
         end
         e_op_itlb_fill:
         begin
            do_fill = cmd_v_i;
         end
         e_op_nop, e_op_reserved:
         begin
            // ignored
         end
      endcase
   end

   // commands win over issue; WAIT issues nothing
   assign issue = ~wait_r & ~do_redirect & ~do_fill & can_load_i;

   assign pc_load_o    = do_redirect;
   assign pc_target_o  = cmd_operand_i.redirect.target;
   assign pc_advance_o = issue & tlb_hit_i;

   assign tlb_w_v_o    = do_fill;
   assign tlb_w_vtag_o = cmd_operand_i.fill.vtag;
   assign tlb_w_ptag_o = cmd_operand_i.fill.ptag;

   assign entry_load_o  = issue;
   assign entry_type_o  = tlb_hit_i ? e_msg_fetch : e_msg_itlb_miss;
   assign entry_vaddr_o = pc_i;
   // miss entries carry no physical address
   assign entry_paddr_o = tlb_hit_i ? {tlb_ptag_i, pc_i[PAGE_OFFSET_W-1:0]}
                                    : '0;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wait_r <= 1'b0;
      end
      else if (wait_r)
      begin
         // fill retries the same pc, redirect moves on
         if (do_redirect | do_fill)
         begin
            wait_r <= 1'b0;
         end
      end
      else if (issue & ~tlb_hit_i)
      begin
         wait_r <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/fe_itlb.sv */
//==========================================================================
// fully associative instruction tlb: zero-latency lookup by vtag, fills
// take effect next cycle and replace round-robin unless the vtag exists
//==========================================================================
`default_nettype none

module fe_itlb
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic [fe_pkg::VTAG_W-1:0]   r_vtag_i,
   input  logic                        w_v_i,
   input  logic [fe_pkg::VTAG_W-1:0]   w_vtag_i,
   input  logic [fe_pkg::PTAG_W-1:0]   w_ptag_i,
   output logic                        hit_o,
   output logic [fe_pkg::PTAG_W-1:0]   ptag_o
);

   import fe_pkg::*;

   logic [ITLB_ENTRIES-1:0] v_r;
   logic [VTAG_W-1:0]       vtag_r [ITLB_ENTRIES];
   logic [PTAG_W-1:0]       ptag_r [ITLB_ENTRIES];
   logic [ITLB_IDX_W-1:0]   rr_ptr_r;

   logic [ITLB_ENTRIES-1:0] r_match;
   logic                    w_match;
   logic [ITLB_IDX_W-1:0]   w_match_idx;
   logic [ITLB_IDX_W-1:0]   w_idx;

   // read side, at most one entry matches since fills never duplicate
   always_comb
   begin
      ptag_o = '0;
      for (int i = 0; i < ITLB_ENTRIES; i++)
      begin
         r_match[i] = v_r[i] & (vtag_r[i] == r_vtag_i);
         ptag_o     = ptag_o | (ptag_r[i] & {PTAG_W{r_match[i]}});
      end
   end

   assign hit_o = |r_match;

   // write side looks for an existing translation of the same page
   always_comb
   begin
      w_match     = 1'b0;
      w_match_idx = '0;
      for (int i = 0; i < ITLB_ENTRIES; i++)
      begin
         if (v_r[i] && (vtag_r[i] == w_vtag_i))
         begin
            w_match     = 1'b1;
            w_match_idx = ITLB_IDX_W'(i);
         end
      end
   end

   assign w_idx = w_match ? w_match_idx : rr_ptr_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         v_r      <= '0;
         rr_ptr_r <= '0;
      end
      else if (w_v_i)
      begin
         v_r[w_idx] <= 1'b1;
         // pointer wraps at eight on its own
         if (!w_match)
         begin
            rr_ptr_r <= rr_ptr_r + ITLB_IDX_W'(1);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         vtag_r[w_idx] <= w_vtag_i;
         ptag_r[w_idx] <= w_ptag_i;
      end
   end

endmodule

`default_nettype wire

/* hw/fe_pc_gen.sv */
//==========================================================================
// program counter: resets to the first pc, steps one instruction on
// advance and takes the redirect target on load
//==========================================================================
`default_nettype none

module fe_pc_gen
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        advance_i,
   input  logic                        load_i,
   input  logic [fe_pkg::VADDR_W-1:0]  target_i,
   output logic [fe_pkg::VADDR_W-1:0]  pc_o
);

   import fe_pkg::*;

   logic [VADDR_W-1:0] pc_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         pc_r <= FIRST_PC;
      end
      else if (load_i)
      begin
         pc_r <= target_i;
      end
      else if (advance_i)
      begin
         pc_r <= pc_r + INSTR_BYTES;
      end
   end

   assign pc_o = pc_r;

endmodule

`default_nettype wire

/* hw/fe_pkg.sv */
//==========================================================================
// shared widths, reset pc, opcode and message encodings for the fetch
// front end; modules import it wildcard-style in their bodies
//==========================================================================
`default_nettype none

package fe_pkg;

   // address geometry
   localparam int VADDR_W       = 32;
   localparam int PAGE_OFFSET_W = 12;
   localparam int VTAG_W        = VADDR_W - PAGE_OFFSET_W;
   localparam int PTAG_W        = 16;
   localparam int PADDR_W       = PTAG_W + PAGE_OFFSET_W;

   // itlb geometry
   localparam int ITLB_ENTRIES = 8;
   localparam int ITLB_IDX_W   = 3;

   localparam logic [VADDR_W-1:0] FIRST_PC    = 32'h0000_1000;
   localparam logic [VADDR_W-1:0] INSTR_BYTES = 32'd4;

   localparam int OPERAND_W = 36;

   // back-end command opcodes, nop and reserved do nothing
   typedef enum logic [1:0]
   {
      e_op_nop         = 2'd0,
      e_op_pc_redirect = 2'd1,
      e_op_itlb_fill   = 2'd2,
      e_op_reserved    = 2'd3
   } fe_opcode_e;

   // kind of entry placed in the queue
   typedef enum logic
   {
      e_msg_fetch     = 1'b0,
      e_msg_itlb_miss = 1'b1
   } fe_msg_type_e;

   // operand word, read as redirect target or as fill translation
   typedef union packed
   {
      struct packed
      {
         logic [OPERAND_W-VADDR_W-1:0] pad;
         logic [VADDR_W-1:0]           target;
      } redirect;
      struct packed
      {
         logic [VTAG_W-1:0] vtag;
         logic [PTAG_W-1:0] ptag;
      } fill;
   } fe_cmd_operand_u;

endpackage

`default_nettype wire

/* hw/fe_queue_reg.sv */
//==========================================================================
// one-entry output stage toward the back end; holds under back-pressure
// and accepts a new entry in the cycle the current one is taken
//==========================================================================
`default_nettype none

module fe_queue_reg
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        load_i,
   input  fe_pkg::fe_msg_type_e        type_i,
   input  logic [fe_pkg::VADDR_W-1:0]  vaddr_i,
   input  logic [fe_pkg::PADDR_W-1:0]  paddr_i,
   input  logic                        ready_i,
   output logic                        can_load_o,
   output logic                        v_o,
   output fe_pkg::fe_msg_type_e        type_o,
   output logic [fe_pkg::VADDR_W-1:0]  vaddr_o,
   output logic [fe_pkg::PADDR_W-1:0]  paddr_o
);

   logic v_r;

   // empty, or the entry leaves this cycle
   assign can_load_o = ~v_r | ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         v_r <= 1'b0;
      end
      else if (load_i)
      begin
         v_r <= 1'b1;
      end
      else if (ready_i)
      begin
         v_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load_i)
      begin
         type_o  <= type_i;
         vaddr_o <= vaddr_i;
         paddr_o <= paddr_i;
      end
   end

   assign v_o = v_r;

endmodule

`default_nettype wire

/* hw/fe_top.sv */
//==========================================================================
// fetch front end top: pc generation, itlb translation and one-entry
// output queue toward the back end, steered by redirect and fill commands
//==========================================================================
`default_nettype none

module fe_top
(
   input  logic                           clk_i,
   input  logic                           reset_i,

   input  logic                           fe_cmd_v_i,
   input  fe_pkg::fe_opcode_e             fe_cmd_opcode_i,
   input  fe_pkg::fe_cmd_operand_u        fe_cmd_operand_i,

   output logic                           fe_queue_v_o,
   input  logic                           fe_queue_ready_i,
   output fe_pkg::fe_msg_type_e           fe_queue_type_o,
   output logic [fe_pkg::VADDR_W-1:0]     fe_queue_vaddr_o,
   output logic [fe_pkg::PADDR_W-1:0]     fe_queue_paddr_o
);

   import fe_pkg::*;

   logic [VADDR_W-1:0] pc;
   logic               pc_advance;
   logic               pc_load;
   logic [VADDR_W-1:0] pc_target;

   logic               tlb_hit;
   logic [PTAG_W-1:0]  tlb_ptag;
   logic               tlb_w_v;
   logic [VTAG_W-1:0]  tlb_w_vtag;
   logic [PTAG_W-1:0]  tlb_w_ptag;

   logic               can_load;
   logic               entry_load;
   fe_msg_type_e       entry_type;
   logic [VADDR_W-1:0] entry_vaddr;
   logic [PADDR_W-1:0] entry_paddr;

   fe_fetch_ctrl u_fetch_ctrl
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cmd_v_i       (fe_cmd_v_i),
      .cmd_opcode_i  (fe_cmd_opcode_i),
      .cmd_operand_i (fe_cmd_operand_i),
      .pc_i          (pc),
      .tlb_hit_i     (tlb_hit),
      .tlb_ptag_i    (tlb_ptag),
      .can_load_i    (can_load),
      .pc_advance_o  (pc_advance),
      .pc_load_o     (pc_load),
      .pc_target_o   (pc_target),
      .tlb_w_v_o     (tlb_w_v),
      .tlb_w_vtag_o  (tlb_w_vtag),
      .tlb_w_ptag_o  (tlb_w_ptag),
      .entry_load_o  (entry_load),
      .entry_type_o  (entry_type),
      .entry_vaddr_o (entry_vaddr),
      .entry_paddr_o (entry_paddr)
   );

   fe_pc_gen u_pc_gen
   (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .advance_i (pc_advance),
      .load_i    (pc_load),
      .target_i  (pc_target),
      .pc_o      (pc)
   );

   // lookup on the page part of the current pc
   fe_itlb u_itlb
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .r_vtag_i (pc[VADDR_W-1:PAGE_OFFSET_W]),
      .w_v_i    (tlb_w_v),
      .w_vtag_i (tlb_w_vtag),
      .w_ptag_i (tlb_w_ptag),
      .hit_o    (tlb_hit),
      .ptag_o   (tlb_ptag)
   );

   fe_queue_reg u_queue_reg
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .load_i     (entry_load),
      .type_i     (entry_type),
      .vaddr_i    (entry_vaddr),
      .paddr_i    (entry_paddr),
      .ready_i    (fe_queue_ready_i),
      .can_load_o (can_load),
      .v_o        (fe_queue_v_o),
      .type_o     (fe_queue_type_o),
      .vaddr_o    (fe_queue_vaddr_o),
      .paddr_o    (fe_queue_paddr_o)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
   --top-module fe_top_tb -o fe_top_tb_sim

out=$(./obj_dir/fe_top_tb_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^TEST PASS$"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

/* vlog.f */
hw/fe_pkg.sv
hw/fe_pc_gen.sv
hw/fe_itlb.sv
hw/fe_queue_reg.sv
hw/fe_fetch_ctrl.sv
hw/fe_top.sv
bench/fe_top_tb.sv
